//--- design/ppm_pkg.sv
package ppm_pkg;

        ////////////////////
        // sample and state types

        // one amplitude sample from the front end
        typedef logic [7:0] sample_t;

        typedef enum logic [1:0] {
                seq_idle,
                seq_preamble,
                seq_decode,
                seq_done
        } seq_state_t;

        // correlation sum for one data bit
        typedef logic signed [31:0] acc_t;

        // preamble length in symbols, data starts right after
        localparam int preamble_symbols = 8;

        ////////////////////
        // bit template

        // early half of the symbol high, late half low
        function automatic acc_t template_weight(
                input int unsigned idx,
                input int unsigned samples_per_symbol
        );
                acc_t weight;

                if (idx < samples_per_symbol / 2) begin
                        weight = acc_t'(1);
                end else begin
                        weight = acc_t'(-1);
                end
                return weight;
        endfunction

endpackage

//--- design/ppm_edge_detector.sv
module ppm_edge_detector import ppm_pkg::*; #(
        parameter int edge_delta = 50
) (
        input  logic    clk,
        input  logic    rst_n,
        input  sample_t sample,
        output sample_t sample_dly,
        output logic    rise,
        output logic    fall
);

        sample_t prev_sample;
        int      step;

        // two stage delay line, prev_sample is the one before sample_dly
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        sample_dly  <= '0;
                        prev_sample <= '0;
                end else begin
                        sample_dly  <= sample;
                        prev_sample <= sample_dly;
                end
        end

        // signed step, wide enough for 0 - 255
        always_comb begin
                step = int'(sample_dly) - int'(prev_sample);
        end

        assign rise = step > edge_delta;
        assign fall = step < -edge_delta;

endmodule

//--- design/ppm_frame_sequencer.sv
module ppm_frame_sequencer import ppm_pkg::*; #(
        parameter int samples_per_symbol = 80,
        parameter int message_bits       = 112,
        parameter int min_pulse_width    = 29
) (
        input  logic                                  clk,
        input  logic                                  rst_n,
        input  logic                                  en,
        input  logic                                  rise,
        input  logic                                  fall,
        output logic [$clog2(samples_per_symbol)-1:0] sample_idx,
        output logic                                  bit_start,
        output logic                                  bit_last,
        output logic                                  frame_start,
        output logic                                  frame_end
);

        localparam int idx_w         = $clog2(samples_per_symbol);
        localparam int frame_symbols = preamble_symbols + message_bits;
        localparam int sym_w         = $clog2(frame_symbols + 1);
        localparam int pos_w         = $clog2(preamble_symbols * samples_per_symbol);

        // expected preamble pulse positions after the first one
        localparam int win_a = samples_per_symbol;
        localparam int win_b = (7 * samples_per_symbol) / 2;
        localparam int win_c = (9 * samples_per_symbol) / 2;

        seq_state_t       state;
        seq_state_t       state_next;
        logic [sym_w-1:0] sym_cnt;
        logic [pos_w-1:0] rise_pos;
        logic             pulse_hit;
        int               pos;
        logic             sym_last;
        logic             in_window;
        logic             window_end;
        logic             abort;
        logic             preamble_done;
        logic             decode_done;

        ////////////////////
        // position and preamble checks

        always_comb begin
                pos = int'(sym_cnt) * samples_per_symbol + int'(sample_idx);
        end

        assign sym_last = sample_idx == idx_w'(samples_per_symbol - 1);

        // +-1 sample around each expected pulse
        assign in_window = (pos >= win_a - 1 && pos <= win_a + 1) ||
                           (pos >= win_b - 1 && pos <= win_b + 1) ||
                           (pos >= win_c - 1 && pos <= win_c + 1);
        assign window_end = pos == win_a + 1 || pos == win_b + 1 || pos == win_c + 1;

        always_comb begin
                abort = 1'b0;
                if (state == seq_preamble) begin
                        // missing pulse
                        if (window_end && !(pulse_hit || rise)) begin
                                abort = 1'b1;
                        end
                        // pulse too narrow
                        if (fall && (pos - int'(rise_pos) < min_pulse_width)) begin
                                abort = 1'b1;
                        end
                end
        end

        assign preamble_done = state == seq_preamble && sym_last &&
                               sym_cnt == sym_w'(preamble_symbols - 1);
        assign decode_done   = state == seq_decode && sym_last &&
                               sym_cnt == sym_w'(frame_symbols - 1);

        ////////////////////
        // FSM

        always_comb begin
                state_next = state;
                case (state)
                        seq_idle: begin
                                if (en && rise) begin
                                        state_next = seq_preamble;
                                end
                        end
                        seq_preamble: begin
                                if (abort) begin
                                        state_next = seq_idle;
                                end else if (preamble_done) begin
                                        state_next = seq_decode;
                                end
                        end
                        seq_decode: begin
                                if (decode_done) begin
                                        state_next = seq_done;
                                end
                        end
                        default: begin
                                state_next = seq_idle;
                        end
                endcase
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state      <= seq_idle;
                        sample_idx <= '0;
                        sym_cnt    <= '0;
                        rise_pos   <= '0;
                        pulse_hit  <= 1'b0;
                end else begin
                        state <= state_next;

                        if (state_next == seq_idle || state_next == seq_done) begin
                                sample_idx <= '0;
                                sym_cnt    <= '0;
                        end else if (state == seq_idle) begin
                                // start edge was position 0
                                sample_idx <= idx_w'(1);
                                sym_cnt    <= '0;
                        end else if (sym_last) begin
                                sample_idx <= '0;
                                sym_cnt    <= sym_cnt + 1'b1;
                        end else begin
                                sample_idx <= sample_idx + 1'b1;
                        end

                        if (state == seq_idle) begin
                                rise_pos <= '0;
                        end else if (state == seq_preamble && rise) begin
                                rise_pos <= pos_w'(pos);
                        end

                        if (state != seq_preamble || window_end) begin
                                pulse_hit <= 1'b0;
                        end else if (rise && in_window) begin
                                pulse_hit <= 1'b1;
                        end
                end
        end

        assign bit_start   = state == seq_decode && sample_idx == '0;
        assign bit_last    = state == seq_decode && sym_last;
        assign frame_start = bit_start && sym_cnt == sym_w'(preamble_symbols);
        // done lines up with the decision of the final bit
        assign frame_end   = state == seq_done;

endmodule

//--- design/ppm_bit_correlator.sv
module ppm_bit_correlator import ppm_pkg::*; #(
        parameter int samples_per_symbol = 80,
        parameter int threshold          = 50
) (
        input  logic                                  clk,
        input  logic                                  rst_n,
        input  sample_t                               sample_dly,
        input  logic [$clog2(samples_per_symbol)-1:0] sample_idx,
        input  logic                                  bit_start,
        input  logic                                  bit_last,
        output logic                                  bit_valid,
        output logic                                  bit_value
);

        acc_t acc;
        acc_t sample_ext;
        acc_t weighted;
        acc_t sum_final;

        assign sample_ext = acc_t'(sample_dly);

        // weight is only ever +1 or -1
        always_comb begin
                if (template_weight(sample_idx, samples_per_symbol) < 0) begin
                        weighted = -sample_ext;
                end else begin
                        weighted = sample_ext;
                end
        end

        // sum including the last sample of the bit
        assign sum_final = acc + weighted;

        always_ff @(posedge clk) begin
                if (bit_start) begin
                        acc <= weighted;
                end else begin
                        acc <= sum_final;
                end
                if (bit_last) begin
                        bit_value <= sum_final > threshold;
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        bit_valid <= 1'b0;
                end else begin
                        bit_valid <= bit_last;
                end
        end

endmodule

//--- design/ppm_message_assembler.sv
module ppm_message_assembler #(
        parameter int message_bits = 112
) (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    bit_valid,
        input  logic                    bit_value,
        input  logic                    frame_start,
        input  logic                    frame_end,
        output logic [message_bits-1:0] data_out,
        output logic                    valid_out
);

        logic [message_bits-1:0] shift_reg;
        logic [message_bits-1:0] shift_next;

        // first bit received ends up in the msb
        assign shift_next = {shift_reg[message_bits-2:0], bit_value};

        always_ff @(posedge clk) begin
                if (frame_start) begin
                        shift_reg <= '0;
                end else if (bit_valid) begin
                        shift_reg <= shift_next;
                end
        end

        ////////////////////
        // held output word

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        data_out  <= '0;
                        valid_out <= 1'b0;
                end else begin
                        valid_out <= frame_end;
                        // last decision arrives with frame_end
                        if (frame_end) begin
                                data_out <= shift_next;
                        end
                end
        end

endmodule

//--- design/ppm_receiver.sv
module ppm_receiver import ppm_pkg::*; #(
        parameter int samples_per_symbol = 80,
        parameter int message_bits       = 112,
        parameter int edge_delta         = 50,
        parameter int min_pulse_width    = 29,
        parameter int threshold          = 50
) (
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    en,
        input  sample_t                 sample,
        output logic [message_bits-1:0] data_out,
        output logic                    valid_out
);

        localparam int idx_w = $clog2(samples_per_symbol);

        sample_t          sample_dly;
        logic             rise;
        logic             fall;
        logic [idx_w-1:0] sample_idx;
        logic             bit_start;
        logic             bit_last;
        logic             frame_start;
        logic             frame_end;
        logic             bit_valid;
        logic             bit_value;

        ////////////////////
        // sample path

        ppm_edge_detector #(
                .edge_delta (edge_delta)
        ) i_edge_detector (
                .clk        (clk),
                .rst_n      (rst_n),
                .sample     (sample),
                .sample_dly (sample_dly),
                .rise       (rise),
                .fall       (fall)
        );

        ppm_frame_sequencer #(
                .samples_per_symbol (samples_per_symbol),
                .message_bits       (message_bits),
                .min_pulse_width    (min_pulse_width)
        ) i_frame_sequencer (
                .clk         (clk),
                .rst_n       (rst_n),
                .en          (en),
                .rise        (rise),
                .fall        (fall),
                .sample_idx  (sample_idx),
                .bit_start   (bit_start),
                .bit_last    (bit_last),
                .frame_start (frame_start),
                .frame_end   (frame_end)
        );

        ////////////////////
        // bit decisions

        ppm_bit_correlator #(
                .samples_per_symbol (samples_per_symbol),
                .threshold          (threshold)
        ) i_bit_correlator (
                .clk        (clk),
                .rst_n      (rst_n),
                .sample_dly (sample_dly),
                .sample_idx (sample_idx),
                .bit_start  (bit_start),
                .bit_last   (bit_last),
                .bit_valid  (bit_valid),
                .bit_value  (bit_value)
        );

        ppm_message_assembler #(
                .message_bits (message_bits)
        ) i_message_assembler (
                .clk         (clk),
                .rst_n       (rst_n),
                .bit_valid   (bit_valid),
                .bit_value   (bit_value),
                .frame_start (frame_start),
                .frame_end   (frame_end),
                .data_out    (data_out),
                .valid_out   (valid_out)
        );

endmodule

//--- testbench/ppm_receiver_assert.sv
module ppm_receiver_assert (
        input logic clk,
        input logic rst_n,
        input logic valid_out,
        input logic frame_end
);

        // failed assertions so far
        int failures = 0;

        // one cycle pulse only
        property valid_single;
                @(posedge clk) disable iff (!rst_n) valid_out |=> !valid_out;
        endproperty

        property valid_low_in_reset;
                @(posedge clk) !rst_n |-> !valid_out;
        endproperty

        // assembler registers the last decision
        property end_gives_valid;
                @(posedge clk) disable iff (!rst_n) frame_end |=> valid_out;
        endproperty

        assert property (valid_single) else begin
                $error("valid_out high on two consecutive cycles");
                failures++;
        end
        assert property (valid_low_in_reset) else begin
                $error("valid_out high during reset");
                failures++;
        end
        assert property (end_gives_valid) else begin
                $error("frame_end not followed by valid_out");
                failures++;
        end

endmodule

bind ppm_receiver ppm_receiver_assert i_assert (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_out (valid_out),
        .frame_end (frame_end)
);

//--- testbench/tb_ppm_receiver.sv
module tb_ppm_receiver import ppm_pkg::*; ();

        localparam int samples_per_symbol = 8;
        localparam int message_bits       = 112;
        localparam int edge_delta         = 50;
        localparam int min_pulse_width    = 3;
        localparam int threshold          = 300;

        localparam int gap_lead       = 40;
        localparam int gap_tail       = 24;
        localparam int preamble_len   = preamble_symbols * samples_per_symbol;
        localparam int frame_len      = (preamble_symbols + message_bits) * samples_per_symbol;
        localparam int test_len       = gap_lead + frame_len + gap_tail;
        localparam int reset_cycles   = 4;
        localparam int drive_skew     = 5;
        localparam int timeout_margin = 256;

        logic                    clk = 1'b0;
        logic                    rst_n;
        logic                    en;
        sample_t                 sample;
        logic [message_bits-1:0] data_out;
        logic                    valid_out;

        // test table with one entry per line of the data file
        string                   t_name[$];
        string                   t_kind[$];
        int                      t_high[$];
        int                      t_low[$];
        int                      t_width[$];
        int                      t_valid[$];
        logic [message_bits-1:0] t_msg[$];
        logic [message_bits-1:0] t_exp[$];

        int                      error_count = 0;
        int                      fail_count = 0;
        int                      valid_seen;
        logic [message_bits-1:0] data_seen;
        int                      cycle_count = 0;
        int                      cycle_limit = 0;
        int unsigned             seed = 32'h79b5;
        bit                      loaded;

        ppm_receiver #(
                .samples_per_symbol (samples_per_symbol),
                .message_bits       (message_bits),
                .edge_delta         (edge_delta),
                .min_pulse_width    (min_pulse_width),
                .threshold          (threshold)
        ) i_dut (
                .clk       (clk),
                .rst_n     (rst_n),
                .en        (en),
                .sample    (sample),
                .data_out  (data_out),
                .valid_out (valid_out)
        );

        always #20 clk = ~clk;

        always @(posedge clk) begin
                cycle_count = cycle_count + 1;
                if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
                        $display("timeout: run did not finish within %0d cycles", cycle_limit);
                        $display("Regression failed");
                        $finish;
                end
        end

        ////////////////////
        // helpers

        task automatic check_value(input string test_name, input logic [message_bits-1:0] expected,
                                   input logic [message_bits-1:0] actual);
                if (actual !== expected) begin
                        $display("[ERROR] %0s: expected %h, actual %h", test_name, expected, actual);
                        error_count++;
                end
        endtask

        task automatic load_tests(output bit ok);
                int                      fd;
                int                      n;
                int                      bad_lines;
                string                   line;
                string                   name;
                string                   kind;
                int                      high;
                int                      low;
                int                      width;
                int                      vld;
                logic [message_bits-1:0] msg;
                logic [message_bits-1:0] exp_data;

                ok = 1'b0;
                bad_lines = 0;
                fd = $fopen("testbench/ppm_tests.txt", "r");
                if (fd == 0) begin
                        $display("could not open testbench/ppm_tests.txt");
                end else begin
                        while (!$feof(fd)) begin
                                line = "";
                                void'($fgets(line, fd));
                                if (line.len() > 0 && line[0] != "#") begin
                                        n = $sscanf(line, "%s %s %d %d %d %h %d %h", name, kind,
                                                    high, low, width, msg, vld, exp_data);
                                        if (n == 8) begin
                                                t_name.push_back(name);
                                                t_kind.push_back(kind);
                                                t_high.push_back(high);
                                                t_low.push_back(low);
                                                t_width.push_back(width);
                                                t_msg.push_back(msg);
                                                t_valid.push_back(vld);
                                                t_exp.push_back(exp_data);
                                        end else if (n > 0) begin
                                                $display("malformed test line: %0s", line);
                                                bad_lines++;
                                        end
                                end
                        end
                        $fclose(fd);
                        ok = t_name.size() > 0 && bad_lines == 0;
                end
        endtask

        // amplitude at one frame position before jitter
        function automatic int frame_level(input int t, input int pos);
                int   starts[4];
                int   data_pos;
                int   bit_idx;
                logic first_half;
                int   level;

                starts = '{0, samples_per_symbol, (7 * samples_per_symbol) / 2,
                           (9 * samples_per_symbol) / 2};
                level = t_low[t];
                if (pos < preamble_len) begin
                        for (int k = 0; k < 4; k++) begin
                                if (pos >= starts[k] && pos < starts[k] + t_width[t] &&
                                    !(t_kind[t] == "missing_pulse" && k == 2)) begin
                                        level = t_high[t];
                                end
                        end
                end else begin
                        data_pos   = pos - preamble_len;
                        bit_idx    = data_pos / samples_per_symbol;
                        first_half = (data_pos % samples_per_symbol) < samples_per_symbol / 2;
                        if (t_msg[t][message_bits-1-bit_idx] == first_half) begin
                                level = t_high[t];
                        end
                end
                return level;
        endfunction

        task automatic drive_sample(input int level);
                @(posedge clk);
                #drive_skew;
                sample = sample_t'(level + int'($urandom % 4));
                @(negedge clk);
                if (valid_out === 1'b1) begin
                        valid_seen++;
                        data_seen = data_out;
                end
        endtask

        task automatic run_test(input int t);
                int errors_before;

                errors_before = error_count;
                valid_seen = 0;
                if (t_kind[t] != "good" && t_kind[t] != "missing_pulse" &&
                    t_kind[t] != "short_pulse" && t_kind[t] != "weak") begin
                        $display("%0s: unknown test kind %0s", t_name[t], t_kind[t]);
                        error_count++;
                end
                repeat (gap_lead) drive_sample(t_low[t]);
                for (int pos = 0; pos < frame_len; pos++) begin
                        drive_sample(frame_level(t, pos));
                end
                repeat (gap_tail) drive_sample(t_low[t]);

                if (t_valid[t] != 0) begin
                        if (valid_seen != 1) begin
                                $display("%0s: expected one valid_out pulse but saw %0d",
                                         t_name[t], valid_seen);
                                error_count++;
                        end else begin
                                check_value(t_name[t], t_exp[t], data_seen);
                        end
                end else begin
                        if (valid_seen != 0) begin
                                $display("%0s: valid_out pulsed for a frame that should abort",
                                         t_name[t]);
                                error_count++;
                        end
                        // aborted frame leaves the previous word in place
                        check_value(t_name[t], t_exp[t], data_out);
                end

                if (error_count == errors_before) begin
                        $display("test %0s: ok", t_name[t]);
                end else begin
                        $display("test %0s: %0d error(s)", t_name[t], error_count - errors_before);
                        fail_count++;
                end
        endtask

        ////////////////////
        // main sequence

        initial begin
                rst_n  = 1'b0;
                en     = 1'b0;
                sample = '0;
                void'($urandom(seed));
                load_tests(loaded);
                if (!loaded) begin
                        $display("no usable tests were loaded");
                        $display("Regression failed");
                        $finish;
                end else begin
                        cycle_limit = reset_cycles + t_name.size() * test_len + timeout_margin;
                        repeat (reset_cycles) @(posedge clk);
                        #drive_skew;
                        rst_n = 1'b1;
                        en    = 1'b1;
                        for (int t = 0; t < t_name.size(); t++) begin
                                run_test(t);
                        end
                        if (i_dut.i_assert.failures > 0) begin
                                $display("bound checker saw %0d assertion failure(s)",
                                         i_dut.i_assert.failures);
                                error_count = error_count + i_dut.i_assert.failures;
                        end
                        $display("%0d tests, %0d failed, %0d errors", t_name.size(), fail_count,
                                 error_count);
                        if (error_count == 0) begin
                                $display("Regression passed");
                        end else begin
                                $display("Regression failed");
                        end
                        $finish;
                end
        end

endmodule

//--- sources.f
design/ppm_pkg.sv
design/ppm_edge_detector.sv
design/ppm_frame_sequencer.sv
design/ppm_bit_correlator.sv
design/ppm_message_assembler.sv
design/ppm_receiver.sv
testbench/ppm_receiver_assert.sv
testbench/tb_ppm_receiver.sv

//--- testbench/ppm_tests.txt
# name kind high low width message_hex valid expected_data_hex
# expected_data is the value data_out holds when the test ends
good_first good 200 10 4 A1B2C3D4E5F60718293A4B5C6D7E 1 A1B2C3D4E5F60718293A4B5C6D7E
miss_zero missing_pulse 200 10 4 0000000000000000000000000000 0 A1B2C3D4E5F60718293A4B5C6D7E
good_after_miss good 200 10 4 8D4840D6202CC371C32CE0576098 1 8D4840D6202CC371C32CE0576098
short_fives short_pulse 200 10 2 5555555555555555555555555555 0 8D4840D6202CC371C32CE0576098
good_after_short good 210 12 4 0123456789ABCDEF0123456789AB 1 0123456789ABCDEF0123456789AB
weak_ones weak 70 10 4 FFFFFFFFFFFFFFFFFFFFFFFFFFFF 1 0000000000000000000000000000
weak_mixed weak 70 10 4 8D4840D6202CC371C32CE0576098 1 0000000000000000000000000000
good_after_weak good 200 10 4 FEDCBA9876543210FEDCBA987654 1 FEDCBA9876543210FEDCBA987654
good_back_a good 180 8 5 5D3C6A1F0E2B4D7C9A8F1E3D5B70 1 5D3C6A1F0E2B4D7C9A8F1E3D5B70
good_back_b good 200 10 4 02E197B0A1C3D5E7F90817263544 1 02E197B0A1C3D5E7F90817263544
miss_ones missing_pulse 200 10 4 FFFFFFFFFFFFFFFFFFFFFFFFFFFF 0 02E197B0A1C3D5E7F90817263544
good_last good 200 10 4 FFFFFFFFFFFFFFFFFFFFFFFFFFFF 1 FFFFFFFFFFFFFFFFFFFFFFFFFFFF
